// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

        // one machine word: data, address and instruction alike
        typedef logic [15:0] word_t;

        // register file index
        typedef logic [3:0] reg_idx_t;

        // kept opcodes, numbered as in the full instruction set
        // codes missing here run as a one-cycle no-op
        typedef enum logic [3:0] {
                op_add  = 4'd0,
                op_addi = 4'd1,
                op_sub  = 4'd2,
                op_sw   = 4'd5,
                op_lw   = 4'd6,
                op_nand = 4'd8,
                op_beq  = 4'd14,
                op_jump = 4'd15
        } opcode_t;

        // every field is one nibble wide
        localparam int field_width = 4;

        // opcode in the top nibble
        localparam int opcode_lsb = 12;

        // destination, or store data register
        localparam int field_c_lsb = 8;

        // base register, or second operand
        localparam int field_b_lsb = 4;

        // first operand, or unsigned immediate
        localparam int field_a_lsb = 0;

        // signed jump displacement in the low bits
        localparam int jump_offset_width = 12;

        // size of the register file
        localparam int reg_count = 16;

endpackage

`default_nettype wire

// ==== source/core_pkg.sv ====
`default_nettype none

package core_pkg;

        // sequencer states
        // execute states share their value with the opcode
        typedef enum logic [4:0] {
                st_add    = 5'd0,
                st_addi   = 5'd1,
                st_sub    = 5'd2,
                st_sw     = 5'd5,
                st_lw     = 5'd6,
                st_nand   = 5'd8,
                st_beq    = 5'd14,
                st_jump   = 5'd15,
                st_fetch  = 5'd16,
                st_beq2   = 5'd19,
                st_sw2    = 5'd20,
                st_decode = 5'd21,
                st_lw2    = 5'd22,
                st_lw3    = 5'd23,
                st_sw3    = 5'd24,
                st_sw4    = 5'd25,
                st_jump2  = 5'd26,
                st_nop    = 5'd28
        } state_t;

        // alu function select
        typedef enum logic [2:0] {
                alu_add  = 3'd0,
                alu_sub  = 3'd1,
                alu_nand = 3'd3
        } alu_op_t;

        // sram write data when no store is in flight
        localparam isa_pkg::word_t idle_store_data = '1;

endpackage

`default_nettype wire

// ==== source/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
        input  logic              clk,
        input  logic              reset,
        input  logic              run_n,
        input  core_pkg::state_t  state,
        input  isa_pkg::word_t    sram_d,
        output isa_pkg::opcode_t  opcode,
        output isa_pkg::word_t    jump_offset,
        output isa_pkg::reg_idx_t rd_a,
        output isa_pkg::reg_idx_t rd_b,
        output isa_pkg::reg_idx_t wr_c,
        output isa_pkg::word_t    imm,
        output logic              imm_en,
        output logic              reg_we,
        output core_pkg::alu_op_t alu_op
);
        import isa_pkg::*;
        import core_pkg::*;

        word_t    instr;
        reg_idx_t field_a;
        reg_idx_t field_b;
        reg_idx_t field_c;

        // instruction register, loaded while the fetch address is on the bus
        // comes out of reset as a jump to itself
        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        instr <= {op_jump, {jump_offset_width{1'b0}}};
                end else if (!run_n && state == st_fetch) begin
                        instr <= sram_d;
                end
        end

        // field split
        assign opcode  = opcode_t'(instr[opcode_lsb +: field_width]);
        assign field_c = instr[field_c_lsb +: field_width];
        assign field_b = instr[field_b_lsb +: field_width];
        assign field_a = instr[field_a_lsb +: field_width];

        // immediate is zero extended, jump displacement sign extended
        assign imm = {{($bits(word_t) - field_width){1'b0}}, field_a};
        assign jump_offset = {{($bits(word_t) - jump_offset_width){instr[jump_offset_width - 1]}},
                              instr[jump_offset_width - 1:0]};

        // operand and writeback selection per state
        always_comb begin
                rd_a   = 4'hf;
                rd_b   = 4'hf;
                wr_c   = 4'hf;
                imm_en = 1'b0;
                reg_we = 1'b0;
                alu_op = alu_add;
                case (state)
                        st_add, st_sub, st_nand: begin
                                rd_a   = field_a;
                                rd_b   = field_b;
                                wr_c   = field_c;
                                reg_we = 1'b1;
                                if (state == st_sub)
                                        alu_op = alu_sub;
                                else if (state == st_nand)
                                        alu_op = alu_nand;
                        end
                        st_addi: begin
                                rd_b   = field_b;
                                wr_c   = field_c;
                                imm_en = 1'b1;
                                reg_we = 1'b1;
                        end
                        // store data on port a, address is base plus imm
                        st_sw, st_sw2, st_sw3, st_sw4: begin
                                rd_a   = field_c;
                                rd_b   = field_b;
                                imm_en = 1'b1;
                        end
                        // load result lands in c on the last load cycle
                        st_lw, st_lw2, st_lw3: begin
                                rd_b   = field_b;
                                wr_c   = field_c;
                                imm_en = 1'b1;
                                reg_we = (state == st_lw3);
                        end
                        // compare c against b, held into beq2 for the zero test
                        st_beq, st_beq2: begin
                                rd_a   = field_c;
                                rd_b   = field_b;
                                alu_op = alu_sub;
                        end
                        default: ;
                endcase
        end

endmodule

`default_nettype wire

// ==== source/sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sequencer #(
        parameter isa_pkg::word_t reset_pc = '0
) (
        input  logic              clk,
        input  logic              reset,
        input  logic              run_n,
        input  isa_pkg::opcode_t  opcode,
        input  isa_pkg::word_t    jump_offset,
        input  logic              zero,
        output core_pkg::state_t  state,
        output isa_pkg::word_t    pc,
        output isa_pkg::word_t    next_fetch
);
        import isa_pkg::*;
        import core_pkg::*;

        state_t state_next;
        word_t  pc_next;
        word_t  branch_disp;

        // branch displacement is field a, the low nibble of the offset word
        assign branch_disp = {{($bits(word_t) - field_width){1'b0}},
                              jump_offset[field_a_lsb +: field_width]};

        // state and pc only move on enabled cycles
        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        state <= st_fetch;
                        pc    <= reset_pc;
                end else if (!run_n) begin
                        state <= state_next;
                        pc    <= pc_next;
                end
        end

        // next state
        always_comb begin
                state_next = st_fetch;
                case (state)
                        st_fetch:
                                state_next = st_decode;
                        st_decode: begin
                                case (opcode)
                                        op_add:  state_next = st_add;
                                        op_addi: state_next = st_addi;
                                        op_sub:  state_next = st_sub;
                                        op_nand: state_next = st_nand;
                                        op_sw:   state_next = st_sw;
                                        op_lw:   state_next = st_lw;
                                        op_beq:  state_next = st_beq;
                                        op_jump: state_next = st_jump;
                                        // dropped opcodes
                                        default: state_next = st_nop;
                                endcase
                        end
                        // store runs four cycles around a single strobe
                        st_sw:
                                state_next = st_sw2;
                        st_sw2:
                                state_next = st_sw3;
                        st_sw3:
                                state_next = st_sw4;
                        // load waits for the data address to reach the sram
                        st_lw:
                                state_next = st_lw2;
                        st_lw2:
                                state_next = st_lw3;
                        st_beq:
                                state_next = st_beq2;
                        st_jump:
                                state_next = st_jump2;
                        // single cycle executes and last states return to fetch
                        default:
                                state_next = st_fetch;
                endcase
        end

        // pc update
        always_comb begin
                pc_next = pc;
                case (state)
                        st_add, st_addi, st_sub, st_nand, st_nop, st_lw3, st_sw4:
                                pc_next = pc + 16'd1;
                        st_beq2: begin
                                if (zero)
                                        pc_next = pc + branch_disp;
                                else
                                        pc_next = pc + 16'd1;
                        end
                        // back one here since jump2 adds one
                        st_jump:
                                pc_next = pc + jump_offset - 16'd1;
                        st_jump2:
                                pc_next = pc + 16'd1;
                        default: ;
                endcase
        end

        // fetch address for the port
        // jump hands out the target one cycle early, no wait on the pc
        assign next_fetch = (state == st_jump) ? pc + jump_offset : pc_next;

endmodule

`default_nettype wire

// ==== source/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module datapath (
        input  logic              clk,
        input  logic              reset,
        input  logic              run_n,
        input  isa_pkg::reg_idx_t rd_a,
        input  isa_pkg::reg_idx_t rd_b,
        input  isa_pkg::reg_idx_t wr_c,
        input  isa_pkg::word_t    imm,
        input  logic              imm_en,
        input  logic              reg_we,
        input  core_pkg::alu_op_t alu_op,
        input  core_pkg::state_t  state,
        input  isa_pkg::word_t    sram_d,
        output isa_pkg::word_t    alu_out,
        output isa_pkg::word_t    store_data,
        output logic              zero
);
        import isa_pkg::*;
        import core_pkg::*;

        word_t regs [reg_count];
        word_t reg_a;
        word_t reg_b;
        word_t op_a;
        word_t wr_data;
        logic  ram_to_reg;

        // asynchronous read ports
        assign reg_a = regs[rd_a];
        assign reg_b = regs[rd_b];

        // port a carries the store data during sw
        assign store_data = reg_a;

        // first operand: register or zero-extended immediate
        assign op_a = imm_en ? imm : reg_a;

        // alu
        always_comb begin
                case (alu_op)
                        alu_add:  alu_out = op_a + reg_b;
                        alu_sub:  alu_out = op_a - reg_b;
                        alu_nand: alu_out = ~(op_a & reg_b);
                        default:  alu_out = op_a + reg_b;
                endcase
        end

        // equal compare for beq
        assign zero = (alu_out == '0);

        // writeback source
        assign ram_to_reg = (state == st_lw) || (state == st_lw2) || (state == st_lw3);
        assign wr_data    = ram_to_reg ? sram_d : alu_out;

        // register file
        // written at the end of the cycle, nothing moves while stalled
        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        for (int i = 0; i < reg_count; i++) begin
                                regs[i] <= '0;
                        end
                end else if (!run_n && reg_we) begin
                        regs[wr_c] <= wr_data;
                end
        end

endmodule

`default_nettype wire

// ==== source/mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_port #(
        parameter isa_pkg::word_t reset_pc = '0
) (
        input  logic             clk,
        input  logic             reset,
        input  logic             run_n,
        input  core_pkg::state_t state,
        input  isa_pkg::word_t   pc,
        input  isa_pkg::word_t   next_fetch,
        input  isa_pkg::word_t   alu_out,
        input  isa_pkg::word_t   store_data,
        output isa_pkg::word_t   sram_addr,
        output isa_pkg::word_t   sram_q,
        output logic             sram_we_n
);
        import core_pkg::*;

        logic we_n_q;

        // pins registered one cycle behind the state that picks them
        always_ff @(posedge clk or negedge reset) begin
                if (!reset) begin
                        sram_addr <= reset_pc;
                        sram_q    <= idle_store_data;
                        we_n_q    <= 1'b1;
                end else if (!run_n) begin
                        sram_q <= idle_store_data;
                        we_n_q <= 1'b1;
                        case (state)
                                st_fetch:
                                        sram_addr <= pc;
                                // effective address held around the strobe
                                st_sw, st_sw2, st_sw3: begin
                                        sram_addr <= alu_out;
                                        sram_q    <= store_data;
                                        we_n_q    <= (state != st_sw2);
                                end
                                st_lw, st_lw2:
                                        sram_addr <= alu_out;
                                // jump included for the early target
                                st_add, st_addi, st_sub, st_nand, st_nop, st_beq2,
                                st_jump, st_jump2, st_lw3, st_sw4:
                                        sram_addr <= next_fetch;
                                // decode and beq keep the address
                                default: ;
                        endcase
                end
        end

        // a held strobe must not write again during a stall
        assign sram_we_n = we_n_q | run_n;

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
        parameter isa_pkg::word_t reset_pc = '0
) (
        input  logic           clk,
        input  logic           reset,
        input  logic           run_n,
        input  isa_pkg::word_t sram_d,
        output isa_pkg::word_t sram_addr,
        output isa_pkg::word_t sram_q,
        output logic           sram_we_n
);
        import isa_pkg::*;
        import core_pkg::*;

        state_t   state;
        opcode_t  opcode;
        alu_op_t  alu_op;
        word_t    pc;
        word_t    next_fetch;
        word_t    jump_offset;
        word_t    imm;
        word_t    alu_out;
        word_t    store_data;
        reg_idx_t rd_a;
        reg_idx_t rd_b;
        reg_idx_t wr_c;
        logic     imm_en;
        logic     reg_we;
        logic     zero;

        // instruction register and field decode
        instr_decode decode_i (
                .clk(clk), .reset(reset), .run_n(run_n), .state(state), .sram_d(sram_d),
                .opcode(opcode), .jump_offset(jump_offset), .rd_a(rd_a), .rd_b(rd_b),
                .wr_c(wr_c), .imm(imm), .imm_en(imm_en), .reg_we(reg_we), .alu_op(alu_op)
        );

        // state machine and pc
        sequencer #(.reset_pc(reset_pc)) seq_i (
                .clk(clk), .reset(reset), .run_n(run_n), .opcode(opcode),
                .jump_offset(jump_offset), .zero(zero), .state(state), .pc(pc),
                .next_fetch(next_fetch)
        );

        // registers and alu
        datapath dp_i (
                .clk(clk), .reset(reset), .run_n(run_n), .rd_a(rd_a), .rd_b(rd_b),
                .wr_c(wr_c), .imm(imm), .imm_en(imm_en), .reg_we(reg_we), .alu_op(alu_op),
                .state(state), .sram_d(sram_d), .alu_out(alu_out), .store_data(store_data),
                .zero(zero)
        );

        // sram pins
        mem_port #(.reset_pc(reset_pc)) port_i (
                .clk(clk), .reset(reset), .run_n(run_n), .state(state), .pc(pc),
                .next_fetch(next_fetch), .alu_out(alu_out), .store_data(store_data),
                .sram_addr(sram_addr), .sram_q(sram_q), .sram_we_n(sram_we_n)
        );

endmodule

`default_nettype wire

// ==== test/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
        import isa_pkg::*;

        localparam word_t start_pc     = 16'h0000;
        localparam int    period       = 20;
        localparam int    reset_cycles = 5;
        localparam int    run_timeout  = 3000;
        // idle cycles watched for extra stores after the last one
        // the program spins in its final jump meanwhile
        localparam int    quiet_cycles = 60;

        logic  clk;
        logic  reset;
        logic  run_n;
        word_t sram_d;
        word_t sram_addr;
        word_t sram_q;
        logic  sram_we_n;

        // sram model and trace contents
        word_t mem [256];
        word_t prog_addr [$];
        word_t prog_data [$];
        word_t exp_addr [$];
        word_t exp_data [$];

        int          store_idx;
        logic        stalls_on;
        logic [31:0] lcg_state;
        logic        failed;

        // pin samples from the previous rising edge
        word_t prev_addr;
        word_t prev_q;
        logic  prev_we_n;
        logic  prev_run_n;
        // pins of the last write for the hold check one cycle later
        logic  check_after;
        word_t wr_addr;
        word_t wr_q;

        cpu_top #(.reset_pc(start_pc)) dut_i (
                .clk(clk), .reset(reset), .run_n(run_n), .sram_d(sram_d),
                .sram_addr(sram_addr), .sram_q(sram_q), .sram_we_n(sram_we_n)
        );

        initial begin
                clk = 1'b0;
                forever #(period / 2) clk = ~clk;
        end

        // asynchronous read follows the address
        assign sram_d = mem[sram_addr[7:0]];

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        task automatic abort_run(input string msg);
                failed = 1'b1;
                $display("%s", msg);
                $display("Something failed");
                $fatal(1, "simulation stopped at first error");
        endtask

        task automatic value_error(input string msg);
                abort_run($sformatf("FAIL at %0t ns: %s", $time, msg));
        endtask

        // P lines fill the program image
        // S lines queue the expected stores in order
        task automatic read_trace();
                int          fd;
                int          code;
                string       line;
                byte         tag;
                logic [15:0] a;
                logic [15:0] d;
                fd = $fopen("test/cpu_trace.txt", "r");
                if (fd == 0) begin
                        abort_run("could not open the trace file test/cpu_trace.txt");
                end else begin
                        while (!$feof(fd)) begin
                                line = "";
                                code = $fgets(line, fd);
                                // comment lines fail the scan and drop out here
                                code = $sscanf(line, "%c %h %h", tag, a, d);
                                if (code == 3 && tag == "P") begin
                                        prog_addr.push_back(a);
                                        prog_data.push_back(d);
                                end else if (code == 3 && tag == "S") begin
                                        exp_addr.push_back(a);
                                        exp_data.push_back(d);
                                end
                        end
                        $fclose(fd);
                end
        endtask

        // address dependent fill with the program laid over it
        // same update region as the model's own writes
        task automatic load_memory();
                for (int i = 0; i < 256; i++) begin
                        mem[i] <= (word_t'(i) * 16'h0101) ^ 16'hff00;
                end
                for (int k = 0; k < prog_addr.size(); k++) begin
                        mem[prog_addr[k]] <= prog_data[k];
                end
        endtask

        task automatic check_reset_pins(input string when);
                assert (sram_we_n === 1'b1)
                else value_error($sformatf("sram_we_n is %b %s", sram_we_n, when));
                assert (sram_addr === start_pc)
                else value_error($sformatf("sram_addr is %h %s, want %h",
                                           sram_addr, when, start_pc));
                assert (sram_q === 16'hffff)
                else value_error($sformatf("sram_q is %h %s, want ffff", sram_q, when));
        endtask

        // image reloaded first so sram_d is never unknown
        task automatic apply_reset();
                load_memory();
                @(negedge clk);
                reset = 1'b0;
                store_idx   = 0;
                check_after = 1'b0;
                for (int i = 0; i < reset_cycles; i++) begin
                        @(negedge clk);
                        check_reset_pins("during reset");
                end
                reset = 1'b1;
                @(negedge clk);
                check_reset_pins("after reset");
        endtask

        // wait for every expected store and watch a quiet tail
        task automatic run_program(input string name);
                int cycles;
                cycles = 0;
                while (store_idx < exp_addr.size() && cycles < run_timeout) begin
                        @(negedge clk);
                        cycles++;
                end
                if (store_idx < exp_addr.size()) begin
                        abort_run($sformatf(
                                "timeout in %s: only %0d of %0d stores seen after %0d cycles",
                                name, store_idx, exp_addr.size(), cycles));
                end else begin
                        repeat (quiet_cycles) @(negedge clk);
                end
        endtask

        // stall injection
        // run_n high about three cycles in eight
        always @(negedge clk) begin
                if (stalls_on) begin
                        lcg_state = lcg_next(lcg_state);
                        run_n     = (lcg_state[31:29] < 3'd3);
                end else begin
                        run_n = 1'b0;
                end
        end

        // sram write and store checks
        // pins are sampled before the edge updates them
        always @(posedge clk) begin
                if (reset) begin
                        // a stalled cycle leaves the pins alone
                        if (prev_run_n) begin
                                assert (sram_addr === prev_addr && sram_q === prev_q)
                                else value_error($sformatf("pins moved in a stall: addr %h q %h",
                                                           sram_addr, sram_q));
                        end
                        assert (!(run_n && sram_we_n === 1'b0))
                        else value_error("write strobe low while run_n is high");
                        if (sram_we_n === 1'b0) begin
                                assert (store_idx < exp_addr.size())
                                else value_error($sformatf("extra store of %h to %h",
                                                           sram_q, sram_addr));
                                assert (sram_addr === exp_addr[store_idx])
                                else value_error($sformatf("store %0d address %h, want %h",
                                                           store_idx, sram_addr, exp_addr[store_idx]));
                                assert (sram_q === exp_data[store_idx])
                                else value_error($sformatf("store %0d data %h, want %h",
                                                           store_idx, sram_q, exp_data[store_idx]));
                                assert (prev_we_n === 1'b1)
                                else value_error("write strobe low for more than one cycle");
                                assert (prev_addr === sram_addr && prev_q === sram_q)
                                else value_error("store address or data not set up a cycle early");
                                mem[sram_addr[7:0]] <= sram_q;
                                store_idx++;
                                check_after = 1'b1;
                                wr_addr     = sram_addr;
                                wr_q        = sram_q;
                        end else if (check_after) begin
                                assert (sram_addr === wr_addr && sram_q === wr_q)
                                else value_error($sformatf(
                                        "store pins changed right after write: %h %h",
                                        sram_addr, sram_q));
                                check_after = 1'b0;
                        end
                end
                prev_addr  = sram_addr;
                prev_q     = sram_q;
                prev_we_n  = sram_we_n;
                prev_run_n = run_n;
        end

        initial begin
                reset       = 1'b0;
                run_n       = 1'b0;
                stalls_on   = 1'b0;
                failed      = 1'b0;
                lcg_state   = 32'h012b_03a8;
                store_idx   = 0;
                check_after = 1'b0;
                prev_we_n   = 1'b1;
                prev_run_n  = 1'b0;
                read_trace();
                assert (exp_addr.size() > 0)
                else abort_run("the trace file holds no expected stores");
                // plain run
                apply_reset();
                run_program("first run");
                // same program again with stalls
                // stalls switch at the rising edge
                apply_reset();
                @(posedge clk);
                stalls_on = 1'b1;
                run_program("stalled run");
                @(posedge clk);
                stalls_on = 1'b0;
                if (!failed) begin
                        $display("Everything OK");
                end else begin
                        $display("Something failed");
                end
                $finish;
        end

endmodule

`default_nettype wire

// ==== test/cpu_trace.txt ====
# columns: kind addr data, values in hex
# kind P is a program word for the sram model, kind S the next expected store
P 0000 1105
P 0001 1203
P 0002 0321
P 0003 2421
P 0004 8521
P 0005 160F
P 0006 0666
P 0007 0666
P 0008 2734
P 0009 5360
P 000A 5461
P 000B 5562
P 000C 5763
P 000D 6860
P 000E 5864
P 000F E832
P 0010 5166
P 0011 E122
P 0012 5265
P 0013 F002
P 0014 5166
P 0015 3111
P 0016 6963
P 0017 5967
P 0018 5168
P 0019 F000
S 003C 0008
S 003D 0002
S 003E FFFE
S 003F FFFA
S 0040 0008
S 0041 0003
S 0043 FFFA
S 0044 0005

// ==== sources.f ====
source/isa_pkg.sv
source/core_pkg.sv
source/instr_decode.sv
source/sequencer.sv
source/datapath.sv
source/mem_port.sv
source/cpu_top.sv
test/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - source/isa_pkg.sv
  - source/core_pkg.sv
  - source/instr_decode.sv
  - source/sequencer.sv
  - source/datapath.sv
  - source/mem_port.sv
  - source/cpu_top.sv
  - target: test
    files:
      - test/cpu_tb.sv
